// ==== source/fxp_pkg.sv ====
package fxp_pkg;

	// word layout: one sign bit above a Q15.16 magnitude
	localparam int FXP_WIDTH = 32;
	localparam int FXP_FRAC = 16;
	localparam int FXP_MAG_W = FXP_WIDTH - 1;

	// reciprocal refinement depth and the resulting request-to-result latency
	localparam int NEWTON_ITERS = 5;
	localparam int DIV_LATENCY = NEWTON_ITERS + 2;

	typedef struct packed {
		logic sign;
		logic [FXP_MAG_W-1:0] mag;
	} fxp_t;

	// 1.0 in this format
	localparam fxp_t FXP_ONE = '{sign: 1'b0, mag: 31'h0001_0000};

	// saturated magnitude, returned on divide by zero
	localparam logic [FXP_MAG_W-1:0] FXP_MAX_MAG = '1;

	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_MUL = 2'd2,
		OP_DIV = 2'd3
	} fxp_op_e;

	typedef struct packed {
		fxp_op_e op;
		fxp_t a;
		fxp_t b;
	} fxp_req_t;

	typedef struct packed {
		fxp_t value;
		logic div_by_zero;
	} fxp_resp_t;

	// state carried from one Newton stage to the next
	// x is the running estimate of 1/|divisor|
	typedef struct packed {
		fxp_t divisor;
		fxp_t dividend;
		fxp_t x;
		logic zero;
	} recip_state_t;

endpackage

// ==== source/fxp_add.sv ====
`timescale 1ns/1ps

module fxp_add
	import fxp_pkg::*;
(
	input fxp_t a,
	input fxp_t b,
	output fxp_t sum
);

	logic a_larger;
	logic same_sign;
	logic [FXP_MAG_W-1:0] mag;
	logic sign;

	always_comb begin
		same_sign = (a.sign == b.sign);
		a_larger = (a.mag >= b.mag);

		if (same_sign) begin
			// plain magnitude add, carry out of the top bit is lost
			mag = a.mag + b.mag;
			sign = a.sign;
		end else if (a_larger) begin
			mag = a.mag - b.mag;
			sign = a.sign;
		end else begin
			// b dominates, so the result follows b
			mag = b.mag - a.mag;
			sign = b.sign;
		end
	end

	// zero is always reported as +0
	always_comb begin
		sum.mag = mag;
		sum.sign = sign & (mag != '0);
	end

endmodule

// ==== source/fxp_mul.sv ====
`timescale 1ns/1ps

module fxp_mul
	import fxp_pkg::*;
(
	input fxp_t a,
	input fxp_t b,
	output fxp_t prod
);

	// full width product of the two magnitudes
	logic [2*FXP_MAG_W-1:0] full;
	logic [FXP_MAG_W-1:0] mag;

	always_comb begin
		full = {{FXP_MAG_W{1'b0}}, a.mag} * {{FXP_MAG_W{1'b0}}, b.mag};
		// drop the low fraction bits (truncation), upper overflow wraps
		mag = full[FXP_FRAC +: FXP_MAG_W];
	end

	always_comb begin
		prod.mag = mag;
		// sign from the operands, except a zero result stays positive
		prod.sign = (a.sign ^ b.sign) & (mag != '0);
	end

endmodule

// ==== source/fxp_recip_seed.sv ====
`timescale 1ns/1ps

module fxp_recip_seed
	import fxp_pkg::*;
(
	input fxp_t divisor,
	output fxp_t seed,
	output logic is_zero
);

	// highest bit index a seed may use
	localparam int TOP_BIT = FXP_MAG_W - 1;
	localparam logic [FXP_MAG_W-1:0] MAG_LSB = 1;

	logic [4:0] lead;
	logic [5:0] raw_pos;
	logic [5:0] pos;

	// leading-one detector, the last hit in the scan is the highest set bit
	always_comb begin
		lead = '0;
		for (int i = 0; i < FXP_MAG_W; i++) begin
			if (divisor.mag[i]) begin
				lead = 5'(i);
			end
		end
	end

	// |d| lies in [2^(p-16), 2^(p-15)), so 2^(16-p) puts d*x in [1, 2)
	// in raw bits that is position 2*FRAC - p
	always_comb begin
		raw_pos = 6'(2 * FXP_FRAC) - {1'b0, lead};
		if (raw_pos > 6'(TOP_BIT)) begin
			// tiny divisors clamp the seed at the top of the magnitude
			pos = 6'(TOP_BIT);
		end else begin
			pos = raw_pos;
		end
	end

	always_comb begin
		seed.sign = 1'b0;
		seed.mag = MAG_LSB << pos;
	end

	assign is_zero = (divisor.mag == '0);

endmodule

// ==== source/fxp_newton_stage.sv ====
`timescale 1ns/1ps

module fxp_newton_stage
	import fxp_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input recip_state_t in_state,
	output logic out_valid,
	output recip_state_t out_state
);

	// the constant 2.0
	localparam fxp_t TWO = '{sign: 1'b0, mag: FXP_ONE.mag << 1};

	fxp_t d_pos;
	fxp_t dx;
	fxp_t neg_dx;
	fxp_t corr;
	fxp_t x_next;

	// the iteration works on |d|, the quotient sign is applied at the end
	assign d_pos = '{sign: 1'b0, mag: in_state.divisor.mag};

	// d * x
	fxp_mul mul_dx (
		.a(d_pos),
		.b(in_state.x),
		.prod(dx)
	);

	assign neg_dx = '{sign: ~dx.sign, mag: dx.mag};

	// 2 - d * x
	fxp_add add_corr (
		.a(TWO),
		.b(neg_dx),
		.sum(corr)
	);

	// x * (2 - d * x)
	fxp_mul mul_x (
		.a(in_state.x),
		.b(corr),
		.prod(x_next)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// operands ride along unchanged, only the estimate moves
	always_ff @(posedge clk) begin
		out_state.divisor <= in_state.divisor;
		out_state.dividend <= in_state.dividend;
		out_state.x <= x_next;
		out_state.zero <= in_state.zero;
	end

endmodule

// ==== source/fxp_div_pipe.sv ====
`timescale 1ns/1ps

module fxp_div_pipe
	import fxp_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input fxp_req_t req,
	output logic out_valid,
	output fxp_resp_t quotient
);

	fxp_t seed;
	logic seed_zero;

	logic seed_valid;
	recip_state_t seed_state;

	// element 0 is the seed register, element i the output of Newton stage i
	logic chain_valid [NEWTON_ITERS+1];
	recip_state_t chain_state [NEWTON_ITERS+1];

	fxp_recip_seed seed0 (
		.divisor(req.b),
		.seed(seed),
		.is_zero(seed_zero)
	);

	// first cycle, capture operands and the power-of-two seed
	always_ff @(posedge clk) begin
		if (rst) begin
			seed_valid <= 1'b0;
		end else begin
			seed_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		seed_state <= '{divisor: req.b, dividend: req.a, x: seed, zero: seed_zero};
	end

	assign chain_valid[0] = seed_valid;
	assign chain_state[0] = seed_state;

	// one register per refinement step
	for (genvar i = 0; i < NEWTON_ITERS; i++) begin : g_newton
		fxp_newton_stage stage (
			.clk(clk),
			.rst(rst),
			.in_valid(chain_valid[i]),
			.in_state(chain_state[i]),
			.out_valid(chain_valid[i+1]),
			.out_state(chain_state[i+1])
		);
	end

	recip_state_t last;
	fxp_t dividend_pos;
	fxp_t q_raw;
	logic q_sign;
	fxp_resp_t q_next;

	assign last = chain_state[NEWTON_ITERS];
	assign dividend_pos = '{sign: 1'b0, mag: last.dividend.mag};

	// |a| * (1/|b|)
	fxp_mul mul_q (
		.a(dividend_pos),
		.b(last.x),
		.prod(q_raw)
	);

	assign q_sign = last.dividend.sign ^ last.divisor.sign;

	always_comb begin
		if (last.zero) begin
			// x/0 saturates with the quotient sign
			q_next.value = '{sign: q_sign, mag: FXP_MAX_MAG};
			q_next.div_by_zero = 1'b1;
		end else begin
			q_next.value.mag = q_raw.mag;
			q_next.value.sign = q_sign & (q_raw.mag != '0);
			q_next.div_by_zero = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= chain_valid[NEWTON_ITERS];
		end
	end

	always_ff @(posedge clk) begin
		quotient <= q_next;
	end

endmodule

// ==== source/fxp_arith_top.sv ====
`timescale 1ns/1ps

module fxp_arith_top
	import fxp_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input fxp_req_t req,
	output logic out_valid,
	output fxp_resp_t resp
);

	// one entry of the add/sub/mul delay line
	typedef struct packed {
		logic valid;
		fxp_op_e op;
		fxp_t result;
	} early_t;

	localparam int TAIL = DIV_LATENCY - 2;

	fxp_t b_eff;
	fxp_t sum;
	fxp_t prod;
	early_t early;

	early_t early_q;
	early_t delay_q [DIV_LATENCY-1];
	early_t tail;

	logic div_valid;
	fxp_resp_t div_resp;

	// subtract is an add with b's sign flipped
	always_comb begin
		b_eff = req.b;
		if (req.op == OP_SUB) begin
			b_eff.sign = ~req.b.sign;
		end
	end

	fxp_add add0 (
		.a(req.a),
		.b(b_eff),
		.sum(sum)
	);

	fxp_mul mul0 (
		.a(req.a),
		.b(req.b),
		.prod(prod)
	);

	always_comb begin
		early.valid = in_valid;
		early.op = req.op;
		case (req.op)
			OP_MUL: early.result = prod;
			// a divide entry only marks its slot, the divider fills it in
			default: early.result = sum;
		endcase
	end

	// the divider sees every request, the op picks the result at the end
	fxp_div_pipe div0 (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.req(req),
		.out_valid(div_valid),
		.quotient(div_resp)
	);

	// early_q is the first-cycle register, then DIV_LATENCY-1 more stages
	always_ff @(posedge clk) begin
		early_q <= early;
		delay_q[0] <= early_q;
		for (int i = 1; i < DIV_LATENCY - 1; i++) begin
			delay_q[i] <= delay_q[i-1];
		end
		if (rst) begin
			early_q.valid <= 1'b0;
			for (int i = 0; i < DIV_LATENCY - 1; i++) begin
				delay_q[i].valid <= 1'b0;
			end
		end
	end

	assign tail = delay_q[TAIL];

	// both paths are DIV_LATENCY deep so results leave in order
	always_comb begin
		if (tail.op == OP_DIV) begin
			out_valid = div_valid;
			resp = div_resp;
		end else begin
			out_valid = tail.valid;
			resp.value = tail.result;
			resp.div_by_zero = 1'b0;
		end
	end

endmodule

// ==== verif/fxp_arith_asserts.sv ====
`timescale 1ns/1ps

module fxp_arith_asserts
	import fxp_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic out_valid,
	input fxp_resp_t resp
);

	// edges since reset was released, saturating at the pipeline depth
	logic [3:0] warm;

	// read by the testbench for its final count
	int fail_count = 0;

	always_ff @(posedge clk) begin
		if (rst) begin
			warm <= '0;
		end else if (warm < 4'(DIV_LATENCY)) begin
			warm <= warm + 4'd1;
		end
	end

	// once the pipe is full, every result lines up with a request DIV_LATENCY edges back
	a_latency: assert property (@(posedge clk) disable iff (rst)
		(warm >= 4'(DIV_LATENCY)) |-> (out_valid == $past(in_valid, DIV_LATENCY)))
	else begin
		fail_count++;
		$error("out_valid does not follow in_valid by the pipeline latency");
	end

	// nothing can come out before the first request has gone through
	a_warmup: assert property (@(posedge clk) disable iff (rst)
		(warm < 4'(DIV_LATENCY)) |-> !out_valid)
	else begin
		fail_count++;
		$error("out_valid high before the first request could reach the output");
	end

	a_reset: assert property (@(posedge clk) $past(rst) |-> !out_valid)
	else begin
		fail_count++;
		$error("out_valid high right after a reset edge");
	end

	// zero must always leave as +0
	a_no_neg_zero: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> !(resp.value.sign && (resp.value.mag == '0)))
	else begin
		fail_count++;
		$error("valid result is a negative zero");
	end

	a_dbz_valid: assert property (@(posedge clk) disable iff (rst)
		resp.div_by_zero |-> out_valid)
	else begin
		fail_count++;
		$error("div_by_zero high while out_valid is low");
	end

endmodule

bind fxp_arith_top fxp_arith_asserts asserts0 (
	.clk(clk),
	.rst(rst),
	.in_valid(in_valid),
	.out_valid(out_valid),
	.resp(resp)
);

// ==== verif/fxp_arith_tb.sv ====
`timescale 1ns/1ps

module fxp_arith_tb;
	import fxp_pkg::*;

	// about 420 requests, six drains and idle gaps, with a wide margin
	localparam int CYCLE_LIMIT = 3000;
	localparam int NUM_TESTS = 6;
	// 2^FXP_FRAC
	localparam real LSB_SCALE = 65536.0;

	// one expected result, tol is the allowed magnitude error in LSBs
	typedef struct packed {
		fxp_t value;
		logic dbz;
		logic [31:0] tol;
		logic [31:0] issued;
		logic [2:0] test_id;
	} expect_t;

	logic clk = 1'b0;
	logic rst;
	logic in_valid;
	fxp_req_t req;
	logic out_valid;
	fxp_resp_t resp;

	int seed = 32'hc004;
	int cycle = 0;
	int checks = 0;
	int stray_errs = 0;
	int cur_test = 0;
	int test_errs [NUM_TESTS];
	expect_t pending [$];

	fxp_arith_top dut0 (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.req(req),
		.out_valid(out_valid),
		.resp(resp)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles with %0d results outstanding", cycle,
				pending.size());
			$display("sim failed");
			$finish;
		end
	end

	function automatic longint to_int(fxp_t x);
		return x.sign ? -longint'(x.mag) : longint'(x.mag);
	endfunction

	function automatic fxp_t to_fxp(longint v);
		fxp_t r;
		r.sign = (v < 0);
		r.mag = 31'((v < 0) ? -v : v);
		return r;
	endfunction

	function automatic real to_real(fxp_t x);
		return real'(to_int(x)) / LSB_SCALE;
	endfunction

	// random sign, magnitude limited to the given number of bits
	function automatic fxp_t rand_fxp(int bits);
		fxp_t v;
		v.sign = 1'($random(seed));
		v.mag = 31'($random(seed)) & ((31'd1 << bits) - 31'd1);
		return v;
	endfunction

	// signed sum of the two values, operands stay small enough not to wrap
	function automatic fxp_t expect_addsub(fxp_op_e op, fxp_t a, fxp_t b);
		longint vb;
		vb = (op == OP_SUB) ? -to_int(b) : to_int(b);
		return to_fxp(to_int(a) + vb);
	endfunction

	function automatic fxp_t expect_mul(fxp_t a, fxp_t b);
		fxp_t r;
		longint full;
		full = longint'(a.mag) * longint'(b.mag);
		r.mag = 31'(full >>> FXP_FRAC);
		// a zero product is +0
		r.sign = (a.sign ^ b.sign) && (r.mag != '0);
		return r;
	endfunction

	// truncated quotient, exact for power-of-two divisors
	function automatic fxp_t expect_div(fxp_t a, fxp_t b);
		fxp_t r;
		r.mag = 31'((longint'(a.mag) << FXP_FRAC) / longint'(b.mag));
		r.sign = (a.sign ^ b.sign) && (r.mag != '0);
		return r;
	endfunction

	task automatic report_mismatch(string sig, longint expv, longint gotv, int id);
		$display("[FAIL] %0t %s expected %0h got %0h (test %0d)", $time, sig, expv, gotv,
			id + 1);
		test_errs[id]++;
	endtask

	// drive one request at the falling edge, in_valid stays high until idle
	task automatic issue(fxp_op_e op, fxp_t a, fxp_t b, fxp_t exp_value, logic exp_dbz,
		int tol);
		expect_t e;
		@(negedge clk);
		in_valid = 1'b1;
		req = '{op: op, a: a, b: b};
		e = '{value: exp_value, dbz: exp_dbz, tol: 32'(tol), issued: 32'(cycle),
			test_id: 3'(cur_test)};
		pending.push_back(e);
	endtask

	task automatic idle(int n);
		repeat (n) begin
			@(negedge clk);
			in_valid = 1'b0;
			req = '0;
		end
	endtask

	task automatic drain_and_report(string name);
		idle(1);
		while (pending.size() != 0) begin
			@(negedge clk);
		end
		$display("test %0d %s: %0d errors", cur_test + 1, name, test_errs[cur_test]);
	endtask

	// scoreboard, results are compared in request order
	always @(negedge clk) begin
		expect_t e;
		longint diff;
		logic exp_sign;
		int lat;
		if (!rst && out_valid) begin
			if (pending.size() == 0) begin
				$display("[FAIL] %0t result came out with no request pending", $time);
				stray_errs++;
			end else begin
				e = pending.pop_front();
				checks++;
				lat = cycle - int'(e.issued);
				if (lat != DIV_LATENCY) begin
					report_mismatch("latency", DIV_LATENCY, lat, int'(e.test_id));
				end
				diff = longint'(resp.value.mag) - longint'(e.value.mag);
				if (diff < 0) begin
					diff = -diff;
				end
				if (diff > longint'(e.tol)) begin
					report_mismatch("resp.value.mag", e.value.mag, resp.value.mag,
						int'(e.test_id));
				end
				// an approximate result that lands on zero must still be +0
				if (e.tol != 0 && resp.value.mag == '0) begin
					exp_sign = 1'b0;
				end else begin
					exp_sign = e.value.sign;
				end
				if (resp.value.sign != exp_sign) begin
					report_mismatch("resp.value.sign", exp_sign, resp.value.sign,
						int'(e.test_id));
				end
				if (resp.div_by_zero != e.dbz) begin
					report_mismatch("resp.div_by_zero", e.dbz, resp.div_by_zero,
						int'(e.test_id));
				end
			end
		end
	end

	initial begin
		fxp_t a;
		fxp_t b;
		fxp_t q;
		fxp_op_e op;
		int lead;
		int total;
		real qm;
		real am;

		rst = 1'b1;
		in_valid = 1'b0;
		req = '0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			test_errs[t] = 0;
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		idle(3);

		cur_test = 0;
		for (int i = 0; i < 100; i++) begin
			op = (i % 2 == 0) ? OP_ADD : OP_SUB;
			a = rand_fxp(30);
			b = rand_fxp(30);
			if (i % 10 == 1) begin
				// a - a must give +0
				b = a;
			end else if (i % 10 == 4) begin
				b = '{sign: ~a.sign, mag: a.mag};
			end
			issue(op, a, b, expect_addsub(op, a, b), 1'b0, 0);
		end
		drain_and_report("add/sub");

		cur_test = 1;
		for (int i = 0; i < 100; i++) begin
			// small pairs truncate to zero
			a = rand_fxp((i % 4 == 0) ? 8 : 23);
			b = rand_fxp((i % 4 == 0) ? 7 : 23);
			issue(OP_MUL, a, b, expect_mul(a, b), 1'b0, 0);
		end
		drain_and_report("multiply");

		cur_test = 2;
		for (int k = -8; k <= 8; k++) begin
			for (int s = 0; s < 2; s++) begin
				a = rand_fxp(22);
				b.sign = 1'(s);
				b.mag = 31'd1 << (FXP_FRAC + k);
				issue(OP_DIV, a, b, expect_div(a, b), 1'b0, 0);
			end
		end
		drain_and_report("divide by 2^k");

		cur_test = 3;
		for (int i = 0; i < 100; i++) begin
			// leading one from 2^-6 to 2^10, mantissa below 1.5
			lead = 10 + int'($unsigned($random(seed)) % 17);
			b = rand_fxp(lead - 1);
			b.mag = b.mag | (31'd1 << lead);
			// dividend sized so the quotient stays below 2^14
			a = rand_fxp((lead + 14 > 31) ? 31 : lead + 14);
			qm = to_real(a) / to_real(b);
			qm = (qm < 0.0) ? -qm : qm;
			am = to_real(a);
			am = (am < 0.0) ? -am : am;
			q.sign = a.sign ^ b.sign;
			q.mag = 31'($rtoi(qm * LSB_SCALE + 0.5));
			// reciprocal held to 16 fraction bits, error scales with the operands
			issue(OP_DIV, a, b, q, 1'b0, 8 + $rtoi((qm + am) * 16.0));
		end
		drain_and_report("general divide");

		cur_test = 4;
		for (int s = 0; s < 2; s++) begin
			a = rand_fxp(30);
			a.sign = 1'(s);
			b = '0;
			q = '{sign: a.sign, mag: FXP_MAX_MAG};
			issue(OP_DIV, a, b, q, 1'b1, 0);
		end
		// the flag must not leak into the next result
		a = rand_fxp(20);
		b = rand_fxp(20);
		issue(OP_ADD, a, b, expect_addsub(OP_ADD, a, b), 1'b0, 0);
		drain_and_report("divide by zero");

		cur_test = 5;
		for (int i = 0; i < 60; i++) begin
			// back-to-back first, then random gaps
			if (i >= 40) begin
				idle(int'($unsigned($random(seed)) % 4));
			end
			op = fxp_op_e'(2'(i % 4));
			a = rand_fxp(20);
			b = rand_fxp(20);
			case (op)
				OP_MUL: q = expect_mul(a, b);
				OP_DIV: begin
					b.mag = 31'd1 << (FXP_FRAC - 4 + (i % 9));
					q = expect_div(a, b);
				end
				default: q = expect_addsub(op, a, b);
			endcase
			issue(op, a, b, q, 1'b0, 0);
		end
		drain_and_report("ordering and throughput");

		total = stray_errs + dut0.asserts0.fail_count;
		for (int t = 0; t < NUM_TESTS; t++) begin
			total += test_errs[t];
		end
		$display("tests %0d, results checked %0d, errors %0d, assertion failures %0d",
			NUM_TESTS, checks, total - dut0.asserts0.fail_count, dut0.asserts0.fail_count);
		if (total == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== fxp_arith_top.f ====
source/fxp_pkg.sv
source/fxp_add.sv
source/fxp_mul.sv
source/fxp_recip_seed.sv
source/fxp_newton_stage.sv
source/fxp_div_pipe.sv
source/fxp_arith_top.sv
verif/fxp_arith_asserts.sv
verif/fxp_arith_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS := --binary --timing --assert -j 0
TOP := fxp_arith_tb
FILELIST := fxp_arith_top.f
OBJ_DIR := obj_dir
SIM_ARGS := +verilator+error+limit+1000
LOG := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -q '^sim passed$$' $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
